// File: all.f
+incdir+bench
src/rp_pkg.sv
src/adc_capture.sv
src/linear_calib.sv
src/dac_formatter.sv
src/analog_frontend_top.sv
bench/tb_top.sv

// File: bench/tb_model.svh
// reference model for the analog datapath testbench
// converter code to signed sample and back to DAC code
// gain and offset calibration with clamping
// check counters and mismatch report

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////////////////////////
// counters
////////////////////////////////////////

int pass_cnt = 0;
int fail_cnt = 0;

// 14-bit two's complement range
localparam longint SMP_HI = 8191;
localparam longint SMP_LO = -8192;

////////////////////////////////////////
// sign conversion
////////////////////////////////////////

// inverted offset binary, code 0 is full positive scale
// so the signed value is 8191 minus the code
function automatic rp_pkg::smp_t adc_code_to_smp(input rp_pkg::adc_raw_t raw);
  longint code;
  longint value;
  code = 64'(raw[15:2]);
  value = SMP_HI - code;
  return value[13:0];
endfunction

// same mapping backwards for the DAC
function automatic logic [13:0] smp_to_dac_code(input rp_pkg::smp_t smp);
  longint value;
  longint code;
  value = 64'(smp);
  code = SMP_HI - value;
  return code[13:0];
endfunction

////////////////////////////////////////
// calibration
////////////////////////////////////////

// gain is Q2.14, shift rounds towards minus infinity
function automatic rp_pkg::smp_t calibrate(input rp_pkg::smp_t smp,
                                           input rp_pkg::calib_cfg_t cfg);
  longint prod;
  longint total;
  prod = 64'(smp) * 64'($signed(cfg.gain));
  total = (prod >>> 14) + 64'($signed(cfg.offs));
  if (total > SMP_HI) begin
    total = SMP_HI;
  end else if (total < SMP_LO) begin
    total = SMP_LO;
  end
  return total[13:0];
endfunction

// one line per wrong value, hex
task automatic report_mismatch(input string sig, input logic [13:0] exp_val,
                               input logic [13:0] act_val);
  fail_cnt += 1;
  $display("FAILED %s expected %h actual %h at %0t", sig, exp_val, act_val, $time);
endtask

`endif

// File: bench/tb_top.sv
// testbench for the analog datapath top level
// clock, reset, random stimulus on the falling edge
// immediate assertions at the rising edge against the model
// per-test lines and the closing report

`timescale 1ns/100ps
`default_nettype none

module tb_top;

  localparam int NUM_CH = 2;
  // deepest latency is 4 cycles
  localparam int HIST = 5;

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic                            adc_clk = 1'b1;
  logic                            top_rst;
  rp_pkg::adc_raw_t   [NUM_CH-1:0] adc_dat_i;
  rp_pkg::smp_t       [NUM_CH-1:0] gen_dat_i;
  rp_pkg::calib_cfg_t [NUM_CH-1:0] adc_cal_i;
  rp_pkg::calib_cfg_t [NUM_CH-1:0] dac_cal_i;
  logic               [NUM_CH-1:0] mux_loop_i;
  rp_pkg::smp_t       [NUM_CH-1:0] acq_dat_o;
  logic               [13:0]       dac_dat_o;
  logic                            dac_sel_o;
  logic                            dac_rst_o;

  integer seed = 32'h3541aa59;
  logic   timed_out = 1'b0;

  `include "tb_model.svh"

  // 4 ns period, first falling edge at 2 ns
  always #2 adc_clk = ~adc_clk;

  analog_frontend_top #(
    .NUM_CH (NUM_CH)
  ) dut_i (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat_i),
    .gen_dat_i  (gen_dat_i),
    .adc_cal_i  (adc_cal_i),
    .dac_cal_i  (dac_cal_i),
    .mux_loop_i (mux_loop_i),
    .acq_dat_o  (acq_dat_o),
    .dac_dat_o  (dac_dat_o),
    .dac_sel_o  (dac_sel_o),
    .dac_rst_o  (dac_rst_o)
  );

  ////////////////////////////////////////
  // checker
  ////////////////////////////////////////

  // input history, index = cycles ago
  rp_pkg::adc_raw_t   [NUM_CH-1:0] adc_h  [0:HIST-1];
  rp_pkg::smp_t       [NUM_CH-1:0] gen_h  [0:HIST-1];
  rp_pkg::calib_cfg_t [NUM_CH-1:0] acal_h [0:HIST-1];
  rp_pkg::calib_cfg_t [NUM_CH-1:0] dcal_h [0:HIST-1];
  logic               [NUM_CH-1:0] mux_h  [0:HIST-1];
  // edges since reset release, current one included
  int   run_cnt = 0;
  logic sel_prev = 1'b0;

  // outputs read here still hold the previous edge's values
  always @(posedge adc_clk) begin
    rp_pkg::smp_t exp_smp;
    logic [13:0]  exp_code;
    int           ch;
    for (int d = HIST - 1; d > 0; d--) begin
      adc_h[d]  = adc_h[d-1];
      gen_h[d]  = gen_h[d-1];
      acal_h[d] = acal_h[d-1];
      dcal_h[d] = dcal_h[d-1];
      mux_h[d]  = mux_h[d-1];
    end
    adc_h[0]  = adc_dat_i;
    gen_h[0]  = gen_dat_i;
    acal_h[0] = adc_cal_i;
    dcal_h[0] = dac_cal_i;
    mux_h[0]  = mux_loop_i;
    if (top_rst) begin
      run_cnt = 0;
    end else begin
      run_cnt = run_cnt + 1;
    end

    // reset values, held one edge past release
    if (top_rst || run_cnt == 1) begin
      assert (dac_rst_o === 1'b1) pass_cnt += 1;
      else report_mismatch("dac_rst_o", 14'h1, {13'h0, dac_rst_o});
      assert (dac_sel_o === 1'b0) pass_cnt += 1;
      else report_mismatch("dac_sel_o", 14'h0, {13'h0, dac_sel_o});
      assert (dac_dat_o === 14'h0) pass_cnt += 1;
      else report_mismatch("dac_dat_o", 14'h0, dac_dat_o);
    end else begin
      assert (dac_rst_o === 1'b0) pass_cnt += 1;
      else report_mismatch("dac_rst_o", 14'h0, {13'h0, dac_rst_o});
    end

    // select toggles on every edge
    if (run_cnt >= 2) begin
      assert (dac_sel_o === ~sel_prev) pass_cnt += 1;
      else report_mismatch("dac_sel_o", {13'h0, ~sel_prev}, {13'h0, dac_sel_o});
    end
    sel_prev = dac_sel_o;

    // data paths once every pipeline stage ran out of reset
    if (run_cnt >= 5) begin
      for (int c = 0; c < NUM_CH; c++) begin
        // mux and adc calibration sampled 2 edges ago
        if (mux_h[2][c]) begin
          exp_smp = calibrate(calibrate(gen_h[4][c], dcal_h[4][c]), acal_h[2][c]);
        end else begin
          exp_smp = calibrate(adc_code_to_smp(adc_h[3][c]), acal_h[2][c]);
        end
        assert (acq_dat_o[c] === exp_smp) pass_cnt += 1;
        else report_mismatch($sformatf("acq_dat_o[%0d]", c), exp_smp, acq_dat_o[c]);
      end
      // sel high shows channel 0
      ch = dac_sel_o ? 0 : 1;
      exp_code = smp_to_dac_code(calibrate(gen_h[4][ch], dcal_h[4][ch]));
      assert (dac_dat_o === exp_code) pass_cnt += 1;
      else report_mismatch("dac_dat_o", exp_code, dac_dat_o);
    end
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  // full-scale words now and then
  function automatic rp_pkg::adc_raw_t random_raw();
    logic [31:0] rnd;
    rnd = $random(seed);
    case (rnd[2:0])
      3'd0:    return 16'h0000;
      3'd1:    return 16'hffff;
      3'd2:    return 16'h8000;
      3'd3:    return 16'h7fff;
      default: return rnd[31:16];
    endcase
  endfunction

  function automatic rp_pkg::smp_t random_smp();
    logic [31:0] rnd;
    rnd = $random(seed);
    case (rnd[2:0])
      3'd0:    return 14'h1fff;
      3'd1:    return 14'h2000;
      default: return rnd[29:16];
    endcase
  endfunction

  // gains close to +2 and -2 are favoured
  function automatic rp_pkg::calib_cfg_t random_cfg();
    rp_pkg::calib_cfg_t cfg;
    logic [31:0]        rnd;
    rnd = $random(seed);
    case (rnd[2:0])
      3'd0:    cfg.gain = 16'h7fff;
      3'd1:    cfg.gain = 16'h8000;
      3'd2:    cfg.gain = {8'h7f, rnd[15:8]};
      3'd3:    cfg.gain = {8'h80, rnd[15:8]};
      3'd4:    cfg.gain = 16'h4000;
      default: cfg.gain = rnd[31:16];
    endcase
    rnd = $random(seed);
    cfg.offs = rnd[13:0];
    return cfg;
  endfunction

  function automatic rp_pkg::calib_cfg_t unity_cfg();
    rp_pkg::calib_cfg_t cfg;
    cfg.gain = 16'h4000;
    cfg.offs = 14'h0;
    return cfg;
  endfunction

  task automatic init_inputs();
    top_rst    = 1'b0;
    adc_dat_i  = '0;
    gen_dat_i  = '0;
    mux_loop_i = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      adc_cal_i[c] = unity_cfg();
      dac_cal_i[c] = unity_cfg();
    end
  endtask

  // 2 cycles of reset, then wait for the DAC reset to drop
  task automatic apply_reset();
    int waited;
    @(negedge adc_clk);
    top_rst = 1'b1;
    repeat (2) @(negedge adc_clk);
    top_rst = 1'b0;
    waited = 0;
    while (dac_rst_o !== 1'b0 && waited < 10) begin
      @(negedge adc_clk);
      waited++;
    end
    if (dac_rst_o !== 1'b0) begin
      $display("timeout, dac_rst_o still high 10 cycles after reset release");
      timed_out = 1'b1;
    end
  endtask

  // calibration words move every 8 cycles
  task automatic run_traffic(input int cycles, input bit rand_acal, input bit rand_dcal,
                             input logic [NUM_CH-1:0] loop_sel);
    for (int i = 0; i < cycles; i++) begin
      @(negedge adc_clk);
      mux_loop_i = loop_sel;
      for (int c = 0; c < NUM_CH; c++) begin
        adc_dat_i[c] = random_raw();
        gen_dat_i[c] = random_smp();
        if (i % 8 == 0) begin
          adc_cal_i[c] = rand_acal ? random_cfg() : unity_cfg();
          dac_cal_i[c] = rand_dcal ? random_cfg() : unity_cfg();
        end
      end
    end
  endtask

  // drain the pipeline, then one line for the test
  task automatic finish_test(input string name, input int pass_start, input int fail_start);
    for (int i = 0; i < HIST + 1; i++) begin
      @(negedge adc_clk);
    end
    $display("test %s: %0d checks, %0d errors", name,
             (pass_cnt - pass_start) + (fail_cnt - fail_start), fail_cnt - fail_start);
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    int p0;
    int f0;
    init_inputs();
    p0 = pass_cnt;
    f0 = fail_cnt;
    apply_reset();
    finish_test("reset", p0, f0);
    if (!timed_out) begin
      p0 = pass_cnt;
      f0 = fail_cnt;
      run_traffic(200, 1'b0, 1'b0, 2'b00);
      finish_test("adc unity", p0, f0);
      p0 = pass_cnt;
      f0 = fail_cnt;
      run_traffic(400, 1'b1, 1'b0, 2'b00);
      finish_test("adc calibration", p0, f0);
      p0 = pass_cnt;
      f0 = fail_cnt;
      run_traffic(300, 1'b0, 1'b1, 2'b00);
      finish_test("dac interleave", p0, f0);
      // one channel looped back at a time
      p0 = pass_cnt;
      f0 = fail_cnt;
      run_traffic(200, 1'b1, 1'b1, 2'b01);
      run_traffic(200, 1'b1, 1'b1, 2'b10);
      finish_test("loopback", p0, f0);
    end
    $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_top

`default_nettype wire

// File: src/analog_frontend_top.sv
// analog datapath top level, single adc_clk domain
// ADC capture with digital loopback
// gain/offset calibration on both directions
// DAC interleave and reset
// instances and wiring only

`timescale 1ns/100ps
`default_nettype none

module analog_frontend_top #(
  // number of analog channels
  parameter int NUM_CH = 2
) (
  // clock and reset
  input  logic                                adc_clk,
  input  logic                                top_rst,
  // ADC converter words
  input  rp_pkg::adc_raw_t   [NUM_CH-1:0]     adc_dat_i,
  // generator samples
  input  rp_pkg::smp_t       [NUM_CH-1:0]     gen_dat_i,
  // calibration, one config per channel
  input  rp_pkg::calib_cfg_t [NUM_CH-1:0]     adc_cal_i,
  input  rp_pkg::calib_cfg_t [NUM_CH-1:0]     dac_cal_i,
  // digital loopback enable per channel
  input  logic               [NUM_CH-1:0]     mux_loop_i,
  // calibrated acquisition samples
  output rp_pkg::smp_t       [NUM_CH-1:0]     acq_dat_o,
  // DAC pins
  output logic               [rp_pkg::SMP_W-1:0] dac_dat_o,
  output logic                                dac_sel_o,
  output logic                                dac_rst_o
);

  ////////////////////////////////////////
  // local signals
  ////////////////////////////////////////

  // calibrated generator samples
  // feed both the DAC and the loopback
  rp_pkg::smp_t [NUM_CH-1:0] gen_cal;

  // captured or looped back samples
  rp_pkg::smp_t [NUM_CH-1:0] adc_smp;

  // top_rst is taken as already synchronous to adc_clk
  // and fans out unchanged to every block

  ////////////////////////////////////////
  // generator calibration
  ////////////////////////////////////////

  // two cycles per channel
  for (genvar i = 0; i < NUM_CH; i++) begin : g_dac_cal

    linear_calib u_dac_calib (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (gen_dat_i[i]),
      .cfg_i   (dac_cal_i[i]),
      .dat_o   (gen_cal[i])
    );

  end : g_dac_cal

  ////////////////////////////////////////
  // DAC output
  ////////////////////////////////////////

  // only two channels reach the DAC bus
  dac_formatter u_dac_formatter (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .ch0_i     (gen_cal[0]),
    .ch1_i     (gen_cal[1]),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_rst_o (dac_rst_o)
  );

  ////////////////////////////////////////
  // ADC capture
  ////////////////////////////////////////

  // one cycle from the pins, loopback is combinational
  adc_capture #(
    .NUM_CH (NUM_CH)
  ) u_adc_capture (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat_i),
    .loop_dat_i (gen_cal),
    .mux_loop_i (mux_loop_i),
    .smp_o      (adc_smp)
  );

  ////////////////////////////////////////
  // acquisition calibration
  ////////////////////////////////////////

  // ADC path: 1 + 2 = 3 cycles
  // loopback path: 2 + 0 + 2 = 4 cycles
  for (genvar i = 0; i < NUM_CH; i++) begin : g_adc_cal

    linear_calib u_adc_calib (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (adc_smp[i]),
      .cfg_i   (adc_cal_i[i]),
      .dat_o   (acq_dat_o[i])
    );

  end : g_adc_cal

endmodule : analog_frontend_top

`default_nettype wire

// File: src/dac_formatter.sv
// DAC output side
// signed to inverted offset binary, both channels
// two-channel interleave onto one bus with select line
// registered DAC reset

`timescale 1ns/100ps
`default_nettype none

module dac_formatter (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  // calibrated generator samples
  input  rp_pkg::smp_t             ch0_i,
  input  rp_pkg::smp_t             ch1_i,
  // DAC pins
  output logic [rp_pkg::SMP_W-1:0] dac_dat_o,
  output logic                     dac_sel_o,
  output logic                     dac_rst_o
);

  ////////////////////////////////////////
  // conversion register
  ////////////////////////////////////////

  // converted words, unsigned on the DAC side
  logic [rp_pkg::SMP_W-1:0] ch0_q;
  logic [rp_pkg::SMP_W-1:0] ch1_q;

  // top bit kept, the rest inverted (negative slope)
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      ch0_q <= '0;
      ch1_q <= '0;
    end else begin
      ch0_q <= {ch0_i[rp_pkg::SMP_W-1], ~ch0_i[rp_pkg::SMP_W-2:0]};
      ch1_q <= {ch1_i[rp_pkg::SMP_W-1], ~ch1_i[rp_pkg::SMP_W-2:0]};
    end
  end

  ////////////////////////////////////////
  // interleave
  ////////////////////////////////////////

  // sel toggles every cycle
  // sel high on the pins: channel 0 on the bus
  // sel low on the pins: channel 1 on the bus
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_sel_o <= 1'b0;
      dac_dat_o <= '0;
    end else begin
      dac_sel_o <= ~dac_sel_o;
      // next sel value decides the channel
      if (~dac_sel_o) begin
        dac_dat_o <= ch0_q;
      end else begin
        dac_dat_o <= ch1_q;
      end
    end
  end

  ////////////////////////////////////////
  // DAC reset
  ////////////////////////////////////////

  // set asynchronously, released on the first edge after top_rst
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_rst_o <= 1'b1;
    end else begin
      dac_rst_o <= 1'b0;
    end
  end

endmodule : dac_formatter

`default_nettype wire

// File: src/linear_calib.sv
// gain and offset calibration for one channel
// stage one: gain multiply, arithmetic shift by the fraction bits
// stage two: offset add and saturation to the sample range
// two cycles latency, one sample per cycle

`timescale 1ns/100ps
`default_nettype none

module linear_calib (
  input  logic               adc_clk,
  input  logic               top_rst,
  // sample in
  input  rp_pkg::smp_t       dat_i,
  // gain and offset
  input  rp_pkg::calib_cfg_t cfg_i,
  // calibrated sample out
  output rp_pkg::smp_t       dat_o
);

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // full product width
  localparam int MUL_W = rp_pkg::SMP_W + rp_pkg::GAIN_W;
  // product after dropping the fraction
  localparam int SHR_W = MUL_W - rp_pkg::GAIN_FRAC;
  // one guard bit for the offset add
  localparam int SUM_W = SHR_W + 1;

  ////////////////////////////////////////
  // stage one
  ////////////////////////////////////////

  // signed times signed
  logic signed [MUL_W-1:0] mul;
  // scaled product
  logic signed [SHR_W-1:0] mul_q;
  // offset travels with its sample
  rp_pkg::offs_t           offs_q;

  assign mul = dat_i * $signed(cfg_i.gain);

  // taking the upper slice is the arithmetic shift right
  // range check: -8192 * -32768 >> 14 = 16384, fits 16 bits
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      mul_q  <= '0;
      offs_q <= '0;
    end else begin
      mul_q  <= mul[MUL_W-1:rp_pkg::GAIN_FRAC];
      offs_q <= cfg_i.offs;
    end
  end

  ////////////////////////////////////////
  // stage two
  ////////////////////////////////////////

  // sum before clamping
  logic signed [SUM_W-1:0] sum;
  // clamped value
  rp_pkg::smp_t            sat;

  // both operands sign extended to SUM_W
  assign sum = mul_q + offs_q;

  // clamp to -8192 .. 8191
  always_comb begin
    if (sum > rp_pkg::SMP_MAX) begin
      sat = rp_pkg::smp_t'(rp_pkg::SMP_MAX);
    end else if (sum < rp_pkg::SMP_MIN) begin
      sat = rp_pkg::smp_t'(rp_pkg::SMP_MIN);
    end else begin
      // in range, plain truncation
      sat = sum[rp_pkg::SMP_W-1:0];
    end
  end

  // output register
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dat_o <= '0;
    end else begin
      dat_o <= sat;
    end
  end

endmodule : linear_calib

`default_nettype wire

// File: src/adc_capture.sv
// ADC input side
// input register per channel
// inverted offset binary to signed conversion
// digital loopback multiplexer per channel

`timescale 1ns/100ps
`default_nettype none

module adc_capture #(
  parameter int NUM_CH = 2
) (
  input  logic                            adc_clk,
  input  logic                            top_rst,
  // raw converter words
  input  rp_pkg::adc_raw_t [NUM_CH-1:0]   adc_dat_i,
  // calibrated generator samples for loopback
  input  rp_pkg::smp_t     [NUM_CH-1:0]   loop_dat_i,
  input  logic             [NUM_CH-1:0]   mux_loop_i,
  // signed samples towards calibration
  output rp_pkg::smp_t     [NUM_CH-1:0]   smp_o
);

  ////////////////////////////////////////
  // capture register
  ////////////////////////////////////////

  // converted sample, one per channel
  rp_pkg::smp_t [NUM_CH-1:0] adc_smp_q;

  // top bit kept, remaining 13 inverted
  // bits 1:0 carry nothing on a 14-bit converter
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_smp_q <= '0;
    end else begin
      for (int i = 0; i < NUM_CH; i++) begin
        adc_smp_q[i] <= {adc_dat_i[i][rp_pkg::ADC_RAW_W-1],
                         ~adc_dat_i[i][rp_pkg::ADC_RAW_W-2:rp_pkg::ADC_RAW_W-rp_pkg::SMP_W]};
      end
    end
  end

  ////////////////////////////////////////
  // loopback mux
  ////////////////////////////////////////

  // combinational, loopback adds no latency
  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      if (mux_loop_i[i]) begin
        smp_o[i] = loop_dat_i[i];
      end else begin
        smp_o[i] = adc_smp_q[i];
      end
    end
  end

endmodule : adc_capture

`default_nettype wire

// File: src/rp_pkg.sv
// shared definitions for the analog datapath
// sample, converter word, gain and offset types
// calibration config struct, one per channel
// fixed-point and saturation constants

`default_nettype none

package rp_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // signed sample width, both directions
  localparam int SMP_W = 14;
  // raw converter word, two lowest bits unused
  localparam int ADC_RAW_W = 16;
  // gain word in Q2.14
  localparam int GAIN_W = 16;
  // fraction bits of the gain, 16384 is unity
  localparam int GAIN_FRAC = 14;
  // offset has the sample width
  localparam int OFFS_W = SMP_W;

  // clamp limits of the sample range
  localparam int SMP_MAX = 2**(SMP_W-1) - 1;
  localparam int SMP_MIN = -(2**(SMP_W-1));

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  typedef logic signed [SMP_W-1:0] smp_t;
  typedef logic [ADC_RAW_W-1:0] adc_raw_t;
  typedef logic signed [GAIN_W-1:0] gain_t;
  typedef logic signed [OFFS_W-1:0] offs_t;

  // per channel calibration, quasi-static
  typedef struct packed {
    gain_t gain;
    offs_t offs;
  } calib_cfg_t;

endpackage : rp_pkg

`default_nettype wire
